// File: blocking_cache.f
source/cache_pkg.sv
source/cache_ctrl_if.sv
source/cache_dpath.sv
source/cache_ctrl.sv
source/blocking_cache.sv
tests/tb_clock.sv
tests/tb_mem_model.sv
tests/tb_blocking_cache.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Build and run the blocking cache testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --timescale 1ns/100ps \
  --top-module tb_blocking_cache \
  -f blocking_cache.f \
  --Mdir obj_dir -o sim_blocking_cache

./obj_dir/sim_blocking_cache | tee sim.log

if grep -q "Finished with no errors" sim.log; then
  echo "Simulation passed"
else
  echo "Simulation failed"
  exit 1
fi

// File: source/blocking_cache.sv
// Blocking direct-mapped write-back cache, 256 bytes
// Joins control unit and datapath

`default_nettype none

module blocking_cache (
  input  logic                         clk,
  input  logic                         reset,

  // Processor side
  input  logic                         cachereq_valid,
  input  cache_pkg::req_op_e           cachereq_op,
  input  logic [cache_pkg::ADDR_W-1:0] cachereq_addr,
  input  logic [cache_pkg::DATA_W-1:0] cachereq_data,
  output logic                         busy,
  output logic                         cacheresp_valid,
  output logic [cache_pkg::DATA_W-1:0] cacheresp_data,

  // Memory side, one line per transfer
  output logic                         memreq_valid,
  output cache_pkg::req_op_e           memreq_op,
  output logic [cache_pkg::ADDR_W-1:0] memreq_addr,
  output logic [cache_pkg::LINE_W-1:0] memreq_data,
  input  logic                         memresp_valid,
  input  logic [cache_pkg::LINE_W-1:0] memresp_data
);

  cache_ctrl_if ctl_if ();

  cache_ctrl u_ctrl (
    .clk             (clk),
    .reset           (reset),
    .cachereq_valid  (cachereq_valid),
    .busy            (busy),
    .cacheresp_valid (cacheresp_valid),
    .memreq_valid    (memreq_valid),
    .memreq_op       (memreq_op),
    .memresp_valid   (memresp_valid),
    .ctl             (ctl_if.ctrl)
  );

  cache_dpath u_dpath (
    .clk            (clk),
    .reset          (reset),
    .cachereq_op    (cachereq_op),
    .cachereq_addr  (cachereq_addr),
    .cachereq_data  (cachereq_data),
    .cacheresp_data (cacheresp_data),
    .memreq_addr    (memreq_addr),
    .memreq_data    (memreq_data),
    .memresp_data   (memresp_data),
    .ctl            (ctl_if.dpath)
  );

endmodule

`default_nettype wire

// File: source/cache_ctrl.sv
// Blocking cache control unit
// Valid and dirty bits per line and the hit/miss state machine

`default_nettype none

module cache_ctrl (
  input  logic               clk,
  input  logic               reset,
  input  logic               cachereq_valid,
  output logic               busy,
  output logic               cacheresp_valid,
  output logic               memreq_valid,
  output cache_pkg::req_op_e memreq_op,
  input  logic               memresp_valid,
  cache_ctrl_if.ctrl         ctl
);

  typedef enum logic [3:0] {
    IDLE,
    TAG_CHECK,
    EVICT_REQ,
    EVICT_WAIT,
    REFILL_REQ,
    REFILL_WAIT,
    REFILL_WRITE,
    READ_DATA,
    RESPOND
  } state_e;

  state_e state_q;
  state_e state_d;

  // --------------------
  // Line status bits
  // --------------------

  logic [cache_pkg::NUM_LINES-1:0] valid_q;
  logic [cache_pkg::NUM_LINES-1:0] dirty_q;

  logic line_valid;
  logic line_dirty;
  logic is_write;
  logic hit;

  assign line_valid = valid_q[ctl.req_idx];
  assign line_dirty = line_valid && dirty_q[ctl.req_idx];  // Stale dirty bits ignored
  assign is_write   = (ctl.req_op == cache_pkg::OP_WRITE);
  assign hit        = line_valid && ctl.tag_match;

  always_ff @(posedge clk) begin
    if (reset) begin
      valid_q <= '0;
      dirty_q <= '0;
    end else begin
      if (state_q == TAG_CHECK && hit && is_write) begin
        dirty_q[ctl.req_idx] <= 1'b1;
      end
      if (state_q == REFILL_WRITE) begin
        valid_q[ctl.req_idx] <= 1'b1;
        dirty_q[ctl.req_idx] <= is_write;  // Fresh line is clean unless a store follows
      end
    end
  end

  // --------------------
  // State register
  // --------------------

  always_ff @(posedge clk) begin
    if (reset) state_q <= IDLE;
    else       state_q <= state_d;
  end

  always_comb begin
    state_d = state_q;
    case (state_q)
      IDLE:         if (cachereq_valid) state_d = TAG_CHECK;
      TAG_CHECK: begin
        if (hit)             state_d = READ_DATA;
        else if (line_dirty) state_d = EVICT_REQ;   // Write back victim first
        else                 state_d = REFILL_REQ;
      end
      EVICT_REQ:    state_d = EVICT_WAIT;
      EVICT_WAIT:   if (memresp_valid) state_d = REFILL_REQ;
      REFILL_REQ:   state_d = REFILL_WAIT;
      REFILL_WAIT:  if (memresp_valid) state_d = REFILL_WRITE;
      REFILL_WRITE: state_d = TAG_CHECK;            // Retry as a hit
      READ_DATA:    state_d = RESPOND;
      RESPOND:      state_d = IDLE;
      default:      state_d = IDLE;
    endcase
  end

  // --------------------
  // Outputs
  // --------------------

  always_comb begin
    ctl.req_en             = 1'b0;
    ctl.tag_wen            = 1'b0;
    ctl.data_wen           = 1'b0;
    ctl.data_src_refill    = 1'b0;
    ctl.memresp_en         = 1'b0;
    ctl.evict_en           = 1'b0;
    ctl.memreq_addr_refill = 1'b0;
    ctl.read_reg_en        = 1'b0;
    memreq_valid           = 1'b0;
    memreq_op              = cache_pkg::OP_READ;

    case (state_q)
      IDLE: ctl.req_en = cachereq_valid;
      TAG_CHECK: begin
        if (hit) begin
          ctl.data_wen = is_write;   // Store merge on a write hit
        end else begin
          ctl.evict_en    = 1'b1;
          ctl.read_reg_en = 1'b1;    // Victim line for writeback
        end
      end
      EVICT_REQ: begin
        memreq_valid = 1'b1;
        memreq_op    = cache_pkg::OP_WRITE;
      end
      REFILL_REQ: begin
        memreq_valid           = 1'b1;
        ctl.memreq_addr_refill = 1'b1;
      end
      REFILL_WAIT: ctl.memresp_en = memresp_valid;
      REFILL_WRITE: begin
        ctl.tag_wen         = 1'b1;
        ctl.data_wen        = 1'b1;
        ctl.data_src_refill = 1'b1;
      end
      READ_DATA: ctl.read_reg_en = 1'b1;
      default: ;
    endcase
  end

  assign busy            = (state_q != IDLE);
  assign cacheresp_valid = (state_q == RESPOND);

endmodule

`default_nettype wire

// File: source/cache_ctrl_if.sv
// Control and status bundle between the cache control unit and its datapath

`default_nettype none

interface cache_ctrl_if;

  // Control unit to datapath
  logic req_en;              // Capture incoming request
  logic tag_wen;
  logic data_wen;
  logic data_src_refill;     // 1 selects refill line, 0 the store merge
  logic memresp_en;          // Capture refill line
  logic evict_en;            // Capture victim address
  logic memreq_addr_refill;  // 1 selects refill address, 0 the victim
  logic read_reg_en;

  // Datapath to control unit
  logic                        tag_match;
  logic [cache_pkg::IDX_W-1:0] req_idx;
  cache_pkg::req_op_e          req_op;

  modport ctrl (
    output req_en, tag_wen, data_wen, data_src_refill,
    output memresp_en, evict_en, memreq_addr_refill, read_reg_en,
    input  tag_match, req_idx, req_op
  );

  modport dpath (
    input  req_en, tag_wen, data_wen, data_src_refill,
    input  memresp_en, evict_en, memreq_addr_refill, read_reg_en,
    output tag_match, req_idx, req_op
  );

endinterface

`default_nettype wire

// File: source/cache_dpath.sv
// Blocking cache datapath
// Request registers, tag and data arrays, refill and eviction paths, response word select

`default_nettype none

module cache_dpath (
  input  logic                         clk,
  input  logic                         reset,
  input  cache_pkg::req_op_e           cachereq_op,
  input  logic [cache_pkg::ADDR_W-1:0] cachereq_addr,
  input  logic [cache_pkg::DATA_W-1:0] cachereq_data,
  output logic [cache_pkg::DATA_W-1:0] cacheresp_data,
  output logic [cache_pkg::ADDR_W-1:0] memreq_addr,
  output logic [cache_pkg::LINE_W-1:0] memreq_data,
  input  logic [cache_pkg::LINE_W-1:0] memresp_data,
  cache_ctrl_if.dpath                  ctl
);

  localparam int BYTE_OFF_W = cache_pkg::OFF_W + 2;  // Word offset plus byte bits

  // --------------------
  // Request registers
  // --------------------

  cache_pkg::req_op_e           req_op_q;
  logic [cache_pkg::ADDR_W-1:0] req_addr_q;
  logic [cache_pkg::DATA_W-1:0] req_data_q;

  always_ff @(posedge clk) begin
    if (reset) begin
      req_op_q   <= cache_pkg::OP_READ;
      req_addr_q <= '0;
    end else if (ctl.req_en) begin
      req_op_q   <= cachereq_op;
      req_addr_q <= cachereq_addr;
    end
  end

  always_ff @(posedge clk) begin
    if (ctl.req_en) req_data_q <= cachereq_data;  // Store word only
  end

  logic [cache_pkg::TAG_W-1:0] req_tag;
  logic [cache_pkg::IDX_W-1:0] req_idx;
  logic [cache_pkg::OFF_W-1:0] req_off;

  assign req_tag = req_addr_q[cache_pkg::ADDR_W-1 -: cache_pkg::TAG_W];
  assign req_idx = req_addr_q[BYTE_OFF_W +: cache_pkg::IDX_W];
  assign req_off = req_addr_q[2 +: cache_pkg::OFF_W];

  assign ctl.req_idx = req_idx;
  assign ctl.req_op  = req_op_q;

  // --------------------
  // Tag and data arrays
  // --------------------

  logic [cache_pkg::TAG_W-1:0]  tag_array  [cache_pkg::NUM_LINES];
  logic [cache_pkg::LINE_W-1:0] data_array [cache_pkg::NUM_LINES];

  logic [cache_pkg::TAG_W-1:0]  stored_tag;
  logic [cache_pkg::LINE_W-1:0] cur_line;
  logic [cache_pkg::LINE_W-1:0] merged_line;
  logic [cache_pkg::LINE_W-1:0] write_line;
  logic [cache_pkg::LINE_W-1:0] refill_q;

  assign stored_tag    = tag_array[req_idx];   // Combinational read
  assign cur_line      = data_array[req_idx];
  assign ctl.tag_match = (stored_tag == req_tag);

  // Store word dropped into the resident line at its offset
  always_comb begin
    merged_line = cur_line;
    merged_line[req_off * cache_pkg::DATA_W +: cache_pkg::DATA_W] = req_data_q;
  end

  assign write_line = ctl.data_src_refill ? refill_q : merged_line;

  always_ff @(posedge clk) begin
    if (ctl.tag_wen)  tag_array[req_idx]  <= req_tag;
    if (ctl.data_wen) data_array[req_idx] <= write_line;
  end

  // --------------------
  // Memory side
  // --------------------

  always_ff @(posedge clk) begin
    if (ctl.memresp_en) refill_q <= memresp_data;
  end

  logic [cache_pkg::ADDR_W-1:0] evict_addr_q;
  logic [cache_pkg::ADDR_W-1:0] refill_addr;

  // Victim address is captured before the refill overwrites the tag
  always_ff @(posedge clk) begin
    if (reset)             evict_addr_q <= '0;
    else if (ctl.evict_en) evict_addr_q <= {stored_tag, req_idx, {BYTE_OFF_W{1'b0}}};
  end

  assign refill_addr = {req_tag, req_idx, {BYTE_OFF_W{1'b0}}};
  assign memreq_addr = ctl.memreq_addr_refill ? refill_addr : evict_addr_q;

  // --------------------
  // Read register and response
  // --------------------

  logic [cache_pkg::LINE_W-1:0] read_q;
  logic [cache_pkg::DATA_W-1:0] resp_word;

  always_ff @(posedge clk) begin
    if (ctl.read_reg_en) read_q <= cur_line;
  end

  assign memreq_data = read_q;  // Victim line during writeback

  assign resp_word = read_q[req_off * cache_pkg::DATA_W +: cache_pkg::DATA_W];

  // Writes answer with zero
  assign cacheresp_data = (req_op_q == cache_pkg::OP_WRITE) ? '0 : resp_word;

endmodule

`default_nettype wire

// File: source/cache_pkg.sv
// Blocking cache package
// Geometry of the direct-mapped cache and the operation encoding shared by all blocks

`default_nettype none

package cache_pkg;

  // --------------------
  // Geometry
  // --------------------

  localparam int ADDR_W    = 32;   // Byte address
  localparam int DATA_W    = 32;   // Processor word
  localparam int LINE_W    = 128;  // Four words per line
  localparam int NUM_LINES = 16;

  // Address split, tag | index | word offset | byte offset
  localparam int IDX_W = 4;        // Bits 7:4
  localparam int OFF_W = 2;        // Bits 3:2
  localparam int TAG_W = 24;       // Bits 31:8

  // --------------------
  // Operations
  // --------------------

  // Shared by processor requests and memory requests
  typedef enum logic {
    OP_READ  = 1'b0,
    OP_WRITE = 1'b1
  } req_op_e;

endpackage

`default_nettype wire

// File: tests/tb_blocking_cache.sv
// Testbench for the blocking cache
// Directed tests against a word image of memory, then a random read/write run

`default_nettype none

module tb_blocking_cache;

  timeunit 1ns;
  timeprecision 100ps;

  logic                         clk;
  logic                         reset;
  logic                         cachereq_valid;
  cache_pkg::req_op_e           cachereq_op;
  logic [cache_pkg::ADDR_W-1:0] cachereq_addr;
  logic [cache_pkg::DATA_W-1:0] cachereq_data;
  logic                         busy;
  logic                         cacheresp_valid;
  logic [cache_pkg::DATA_W-1:0] cacheresp_data;
  logic                         memreq_valid;
  cache_pkg::req_op_e           memreq_op;
  logic [cache_pkg::ADDR_W-1:0] memreq_addr;
  logic [cache_pkg::LINE_W-1:0] memreq_data;
  logic                         memresp_valid;
  logic [cache_pkg::LINE_W-1:0] memresp_data;

  int                           rd_count;
  int                           wr_count;
  logic [cache_pkg::ADDR_W-1:0] last_rd_addr;
  logic [cache_pkg::ADDR_W-1:0] last_wr_addr;
  logic [cache_pkg::LINE_W-1:0] last_wr_line;

  logic [31:0] image [256];  // Expected word at each address of the 1 KB range
  int          error_count;
  int          tests_passed;
  logic        hung = 1'b0;
  event        never_evt;

  tb_clock u_clock (.clk(clk));

  blocking_cache dut (.*);

  tb_mem_model u_mem (.*);

  // --------------------
  // Helpers
  // --------------------

  function automatic logic [31:0] pattern_word(input logic [31:0] addr);
    return (addr * 32'h0001_0001) ^ 32'h5a5a_a5a5;
  endfunction

  function automatic logic [127:0] expected_line(input logic [31:0] addr);
    logic [7:0] base;
    base = {addr[9:4], 2'b00};
    return {image[base + 8'd3], image[base + 8'd2], image[base + 8'd1], image[base]};
  endfunction

  task automatic report_error(input string msg);
    error_count++;
    $display("ERROR @ %0t: %s", $time, msg);
  endtask

  // One request, cycles counted from the accepting edge to the response
  task automatic cache_access(input cache_pkg::req_op_e op, input logic [31:0] addr,
                              input logic [31:0] wdata, output logic [31:0] rdata,
                              output int cycles);
    if (busy) report_error($sformatf("busy high when issuing request to %h", addr));
    cachereq_valid = 1'b1;
    cachereq_op    = op;
    cachereq_addr  = addr;
    cachereq_data  = wdata;
    @(posedge clk);
    #1 cachereq_valid = 1'b0;
    cycles = 1;
    while (!cacheresp_valid && cycles < 200) begin
      if (!busy) report_error($sformatf("busy low while request to %h is pending", addr));
      @(posedge clk);
      #1 cycles++;
    end
    if (!cacheresp_valid) begin
      $display("No response from the cache within 200 cycles for address %h", addr);
      hung = 1'b1;
      @(never_evt);
    end else begin
      rdata = cacheresp_data;
      if (!busy) report_error($sformatf("busy low in the response cycle for %h", addr));
      @(posedge clk);  // Back to idle
      #1;
      if (cacheresp_valid) report_error($sformatf("response for %h longer than a cycle", addr));
    end
  endtask

  task automatic read_check(input logic [31:0] addr, output int cycles);
    logic [31:0] rdata;
    cache_access(cache_pkg::OP_READ, addr, 32'h0, rdata, cycles);
    if (rdata !== image[addr[9:2]])
      report_error($sformatf("read %h got %h, expected %h", addr, rdata, image[addr[9:2]]));
  endtask

  task automatic write_word(input logic [31:0] addr, input logic [31:0] data);
    logic [31:0] rdata;
    int          cycles;
    cache_access(cache_pkg::OP_WRITE, addr, data, rdata, cycles);
    image[addr[9:2]] = data;
    if (rdata !== 32'h0) report_error($sformatf("write %h answered %h, not zero", addr, rdata));
  endtask

  task automatic finish_test(input string name, input int errors_before);
    if (error_count == errors_before) begin
      tests_passed++;
      $display("%-22s passed", name);
    end else begin
      $display("%-22s failed, %0d errors", name, error_count - errors_before);
    end
  endtask

  // --------------------
  // Tests
  // --------------------

  task automatic test_read_miss_hit();
    int e0 = error_count;
    int rd0 = rd_count;
    int wr0 = wr_count;
    int cycles;
    read_check(32'h24, cycles);  // Cold miss
    if (rd_count != rd0 + 1) report_error("cold read did not make exactly one memory read");
    if (last_rd_addr != 32'h20) report_error($sformatf("refill address %h", last_rd_addr));
    rd0 = rd_count;
    read_check(32'h2c, cycles);
    if (cycles != 3) report_error($sformatf("hit took %0d cycles, expected 3", cycles));
    if (rd_count != rd0 || wr_count != wr0) report_error("hit made a memory request");
    finish_test("read miss then hit", e0);
  endtask

  task automatic test_write_hit();
    int e0 = error_count;
    int rd0 = rd_count;
    int wr0 = wr_count;
    int cycles;
    write_word(32'h28, 32'hcafe_f00d);
    read_check(32'h28, cycles);
    read_check(32'h20, cycles);  // Neighbours
    read_check(32'h24, cycles);
    read_check(32'h2c, cycles);
    if (rd_count != rd0 || wr_count != wr0) report_error("write hit made a memory request");
    finish_test("write hit, read back", e0);
  endtask

  task automatic test_dirty_evict();
    int           e0 = error_count;
    int           rd0;
    int           wr0;
    int           cycles;
    logic [127:0] victim;
    write_word(32'h54, 32'h1234_5678);  // Index 5 becomes dirty
    victim = expected_line(32'h50);
    rd0 = rd_count;
    wr0 = wr_count;
    read_check(32'h354, cycles);  // Same index, tag 3
    if (wr_count != wr0 + 1) report_error("conflict on dirty line made no single writeback");
    if (last_wr_addr != 32'h50) report_error($sformatf("writeback address %h", last_wr_addr));
    if (last_wr_line !== victim) report_error($sformatf("writeback line %h", last_wr_line));
    if (rd_count != rd0 + 1 || last_rd_addr != 32'h350) report_error("refill after writeback");
    read_check(32'h54, cycles);  // Comes back from memory
    if (wr_count != wr0 + 1) report_error("clean line written back");
    finish_test("dirty eviction", e0);
  endtask

  task automatic test_clean_evict();
    int e0 = error_count;
    int rd0;
    int wr0;
    int cycles;
    read_check(32'h68, cycles);
    rd0 = rd_count;
    wr0 = wr_count;
    read_check(32'h268, cycles);
    if (wr_count != wr0) report_error("clean eviction made a write request");
    if (rd_count != rd0 + 1) report_error("clean eviction did not refill once");
    finish_test("clean eviction", e0);
  endtask

  task automatic test_random();
    int          e0 = error_count;
    int          cycles;
    logic [31:0] addr;
    for (int n = 0; n < 200; n++) begin
      addr = ($urandom % 256) * 4;
      if ($urandom % 2 == 1) write_word(addr, $urandom);
      else                   read_check(addr, cycles);
    end
    finish_test("random sequence", e0);
  endtask

  // --------------------
  // Run
  // --------------------

  initial begin
    wait (hung);
    $display("Finished with errors");
    $finish;
  end

  initial begin
    void'($urandom(32'hc573deba));
    reset          = 1'b1;
    cachereq_valid = 1'b0;
    cachereq_op    = cache_pkg::OP_READ;
    cachereq_addr  = '0;
    cachereq_data  = '0;
    error_count    = 0;
    tests_passed   = 0;
    for (int i = 0; i < 256; i++) image[i] = pattern_word(i * 4);
    repeat (4) @(posedge clk);
    #1 reset = 1'b0;

    test_read_miss_hit();
    test_write_hit();
    test_dirty_evict();
    test_clean_evict();
    test_random();

    $display("Tests passed: %0d of 5, errors: %0d", tests_passed, error_count);
    if (error_count == 0) begin
      $display("Finished with no errors");
    end else begin
      $display("Finished with errors");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: tests/tb_clock.sv
// Testbench clock source, 4 ns period

`default_nettype none

module tb_clock (
  output logic clk
);

  timeunit 1ns;
  timeprecision 100ps;

  initial clk = 1'b0;

  always #2 clk = ~clk;  // Half period

endmodule

`default_nettype wire

// File: tests/tb_mem_model.sv
// Backing memory for the cache testbench, 1 KB of 16-byte lines
// Answers each line request after 1 to 6 cycles and counts reads and writes

`default_nettype none

module tb_mem_model (
  input  logic                         clk,
  input  logic                         reset,
  input  logic                         memreq_valid,
  input  cache_pkg::req_op_e           memreq_op,
  input  logic [cache_pkg::ADDR_W-1:0] memreq_addr,
  input  logic [cache_pkg::LINE_W-1:0] memreq_data,
  output logic                         memresp_valid,
  output logic [cache_pkg::LINE_W-1:0] memresp_data,
  output int                           rd_count,
  output int                           wr_count,
  output logic [cache_pkg::ADDR_W-1:0] last_rd_addr,
  output logic [cache_pkg::ADDR_W-1:0] last_wr_addr,
  output logic [cache_pkg::LINE_W-1:0] last_wr_line
);

  timeunit 1ns;
  timeprecision 100ps;

  logic [cache_pkg::LINE_W-1:0] mem [64];  // Line addressed, bits 9:4
  logic [cache_pkg::LINE_W-1:0] resp_line;
  logic                         pending;
  int                           countdown;

  // Initial word at a byte address, mixes all address bits
  function automatic logic [31:0] pattern_word(input logic [31:0] addr);
    return (addr * 32'h0001_0001) ^ 32'h5a5a_a5a5;
  endfunction

  initial begin
    for (int i = 0; i < 64; i++) begin
      for (int w = 0; w < 4; w++) begin
        mem[i][w * cache_pkg::DATA_W +: cache_pkg::DATA_W] = pattern_word(i * 16 + w * 4);
      end
    end
  end

  always @(posedge clk) begin
    if (reset) begin
      memresp_valid <= 1'b0;
      memresp_data  <= '0;
      pending       <= 1'b0;
      countdown     <= 0;
      rd_count      <= 0;
      wr_count      <= 0;
    end else begin
      memresp_valid <= 1'b0;
      if (memreq_valid) begin
        pending   <= 1'b1;
        countdown <= 1 + int'($urandom % 6);  // Latency 1 to 6
        if (memreq_op == cache_pkg::OP_WRITE) begin
          mem[memreq_addr[9:4]] <= memreq_data;
          wr_count              <= wr_count + 1;
          last_wr_addr          <= memreq_addr;
          last_wr_line          <= memreq_data;
        end else begin
          resp_line    <= mem[memreq_addr[9:4]];
          rd_count     <= rd_count + 1;
          last_rd_addr <= memreq_addr;
        end
      end else if (pending) begin
        if (countdown == 1) begin
          memresp_valid <= 1'b1;
          memresp_data  <= resp_line;
          pending       <= 1'b0;
        end
        countdown <= countdown - 1;
      end
    end
  end

endmodule

`default_nettype wire
